//--- design/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Low PC bits joined to the history for the gselect index
`define BP_PC_W 4

// Global history length shared by both tables
`define BP_HIST_W 4

// Low PC bits selecting a perceptron entry
`define BP_PT_PC_W 4

// Signed width of each perceptron weight
`define BP_WEIGHT_W 6

// Perceptron keeps training while the sum magnitude is at or below this
`define BP_THETA 8

// Low PC bits selecting a chooser entry
`define BP_SEL_PC_W 4

`endif

//--- design/bp_ctrl_pkg.sv
package bp_ctrl_pkg;

    // Chooser counter, ordered so that stepping up moves toward the perceptron
    typedef enum logic [1:0] {
        strong_gselect    = 2'b00,
        weak_gselect      = 2'b01,
        weak_perceptron   = 2'b10,
        strong_perceptron = 2'b11
    } sel_state_e;

    // Component that supplied a response
    typedef enum logic {
        prov_gselect    = 1'b0,
        prov_perceptron = 1'b1
    } provider_e;

endpackage

//--- design/bp_types_pkg.sv
`include "bp_defines.svh"

package bp_types_pkg;

    typedef struct packed {
        logic [31:0] pc;
    } bp_req_t;

    // Registered request plus the history it was looked up under
    typedef struct packed {
        logic [31:0]           pc;
        logic [`BP_HIST_W-1:0] hist;
    } bp_lookup_t;

    typedef struct packed {
        logic [31:0]             pc;
        logic                    taken;
        bp_ctrl_pkg::provider_e  provider;
    } bp_rsp_t;

    // The hist field is the history before the resolved branch shifts in
    typedef struct packed {
        logic [31:0]           pc;
        logic                  taken;
        logic [`BP_HIST_W-1:0] hist;
    } bp_upd_t;

endpackage

//--- design/bp_update_stage.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module bp_update_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    upd_valid,
    output logic                    upd_ready,
    input  logic [31:0]             upd_pc,
    input  logic                    upd_taken,
    output logic                    train_valid,
    output bp_types_pkg::bp_upd_t   train,
    output logic [`BP_HIST_W-1:0]   hist
);

    // Updates are always accepted outside reset
    assign upd_ready   = !rst;
    assign train_valid = upd_valid && upd_ready;

    // Tables train under the history as it stood before this branch
    assign train = '{pc: upd_pc, taken: upd_taken, hist: hist};

    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '0;
        end else if (train_valid) begin
            hist <= {hist[`BP_HIST_W-2:0], upd_taken};
        end
    end

    // Without speculative history the register only moves on resolved branches
    a_hist_only_on_update: assert property (
        @(posedge clk) disable iff (rst)
        !train_valid |=> $stable(hist)
    );

endmodule

//--- design/bp_lookup_stage.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module bp_lookup_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  bp_types_pkg::bp_req_t     req,
    input  logic [`BP_HIST_W-1:0]     hist,
    input  logic                      advance,
    output logic                      look_valid,
    output bp_types_pkg::bp_lookup_t  look
);

    logic req_fire;

    // One entry, so a new request fits only if the current one moves on
    assign req_ready = !rst && (!look_valid || advance);
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            look_valid <= 1'b0;
        end else if (req_fire) begin
            look_valid <= 1'b1;
        end else if (advance) begin
            look_valid <= 1'b0;
        end
    end

    // Snapshot the history together with the PC
    always_ff @(posedge clk) begin
        if (req_fire) begin
            look.pc   <= req.pc;
            look.hist <= hist;
        end
    end

    // The tables read this register directly, so it must not move under a stall
    a_look_stable: assert property (
        @(posedge clk) disable iff (rst)
        look_valid && !advance |=> look_valid && $stable(look)
    );

endmodule

//--- design/gselect_table.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module gselect_table (
    input  logic                      clk,
    input  logic                      rst,
    input  bp_types_pkg::bp_lookup_t  look,
    output logic                      pred,
    input  logic                      train_valid,
    input  bp_types_pkg::bp_upd_t     train,
    output logic                      train_pred
);

    localparam int IDX_W   = `BP_HIST_W + `BP_PC_W;
    localparam int ENTRIES = 1 << IDX_W;

    logic [1:0]       pht [ENTRIES];
    logic [IDX_W-1:0] look_idx;
    logic [IDX_W-1:0] train_idx;
    logic [1:0]       cnt;

    // History in the upper bits, low PC bits below
    assign look_idx  = {look.hist, look.pc[`BP_PC_W-1:0]};
    assign train_idx = {train.hist, train.pc[`BP_PC_W-1:0]};

    assign pred       = pht[look_idx][1];
    assign cnt        = pht[train_idx];
    assign train_pred = cnt[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (train_valid) begin
            if (train.taken && cnt != 2'b11) begin
                pht[train_idx] <= cnt + 2'd1;
            end else if (!train.taken && cnt != 2'b00) begin
                pht[train_idx] <= cnt - 2'd1;
            end
        end
    end

endmodule

//--- design/perceptron_table.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module perceptron_table (
    input  logic                      clk,
    input  logic                      rst,
    input  bp_types_pkg::bp_lookup_t  look,
    output logic                      pred,
    input  logic                      train_valid,
    input  bp_types_pkg::bp_upd_t     train,
    output logic                      train_pred
);

    localparam int W       = `BP_WEIGHT_W;
    localparam int ENTRIES = 1 << `BP_PT_PC_W;
    localparam int SUM_W   = W + $clog2(`BP_HIST_W + 1) + 1;
    localparam logic signed [SUM_W-1:0] THETA_S = `BP_THETA;
    localparam logic [W-1:0] W_MAX = {1'b0, {(W-1){1'b1}}};
    localparam logic [W-1:0] W_MIN = {1'b1, {(W-1){1'b0}}};

    // Element 0 is the bias, element i+1 pairs with history bit i
    typedef logic [`BP_HIST_W:0][W-1:0] entry_t;

    entry_t                   wt [ENTRIES];
    logic [`BP_PT_PC_W-1:0]   look_idx;
    logic [`BP_PT_PC_W-1:0]   train_idx;
    logic signed [SUM_W-1:0]  look_sum;
    logic signed [SUM_W-1:0]  train_sum;
    logic                     in_margin;
    logic                     do_train;

    function automatic logic signed [SUM_W-1:0] dot(input entry_t e,
                                                    input logic [`BP_HIST_W-1:0] h);
        logic signed [SUM_W-1:0] acc;
        acc = $signed(e[0]);
        for (int i = 0; i < `BP_HIST_W; i++) begin
            // A set history bit counts as +1, a clear one as -1
            if (h[i]) begin
                acc = acc + $signed(e[i+1]);
            end else begin
                acc = acc - $signed(e[i+1]);
            end
        end
        return acc;
    endfunction

    function automatic logic [W-1:0] sat_step(input logic [W-1:0] w, input logic up);
        logic [W-1:0] n;
        n = w;
        if (up && w != W_MAX) begin
            n = w + 1'b1;
        end else if (!up && w != W_MIN) begin
            n = w - 1'b1;
        end
        return n;
    endfunction

    function automatic logic step_ok(input logic [W-1:0] a, input logic [W-1:0] b);
        logic signed [W:0] d;
        d = $signed(b) - $signed(a);
        return (d >= -1) && (d <= 1);
    endfunction

    assign look_idx  = look.pc[`BP_PT_PC_W-1:0];
    assign train_idx = train.pc[`BP_PT_PC_W-1:0];

    assign look_sum  = dot(wt[look_idx], look.hist);
    assign train_sum = dot(wt[train_idx], train.hist);

    assign pred       = !look_sum[SUM_W-1];
    assign train_pred = !train_sum[SUM_W-1];

    assign in_margin = (train_sum <= THETA_S) && (train_sum >= -THETA_S);
    assign do_train  = train_valid && ((train_pred != train.taken) || in_margin);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                wt[i] <= '0;
            end
        end else if (do_train) begin
            wt[train_idx][0] <= sat_step(wt[train_idx][0], train.taken);
            for (int i = 0; i < `BP_HIST_W; i++) begin
                wt[train_idx][i+1] <= sat_step(wt[train_idx][i+1],
                                               train.hist[i] == train.taken);
            end
        end
    end

    // A trained weight moves one step at most, so it can never wrap past a limit
    for (genvar k = 0; k <= `BP_HIST_W; k++) begin : g_range_chk
        a_weight_range: assert property (
            @(posedge clk) disable iff (rst)
            do_train |=> step_ok($past(wt[train_idx][k]), wt[$past(train_idx)][k])
        );
    end

endmodule

//--- design/tournament_chooser.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module tournament_chooser (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      look_valid,
    input  bp_types_pkg::bp_lookup_t  look,
    input  logic                      gs_pred,
    input  logic                      pc_pred,
    output logic                      advance,
    input  logic                      train_valid,
    input  bp_types_pkg::bp_upd_t     train,
    input  logic                      gs_train_pred,
    input  logic                      pc_train_pred,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output bp_types_pkg::bp_rsp_t     rsp
);

    import bp_ctrl_pkg::*;

    localparam int ENTRIES = 1 << `BP_SEL_PC_W;

    sel_state_e               sel [ENTRIES];
    logic [`BP_SEL_PC_W-1:0]  look_idx;
    logic [`BP_SEL_PC_W-1:0]  train_idx;
    provider_e                look_prov;
    logic                     look_taken;

    function automatic sel_state_e step_sel(input sel_state_e s, input logic to_perc);
        sel_state_e n;
        n = s;
        case (s)
            strong_gselect:    n = to_perc ? weak_gselect : strong_gselect;
            weak_gselect:      n = to_perc ? weak_perceptron : strong_gselect;
            weak_perceptron:   n = to_perc ? strong_perceptron : weak_gselect;
            strong_perceptron: n = to_perc ? strong_perceptron : weak_perceptron;
            default:           n = weak_gselect;
        endcase
        return n;
    endfunction

    assign look_idx  = look.pc[`BP_SEL_PC_W-1:0];
    assign train_idx = train.pc[`BP_SEL_PC_W-1:0];

    assign look_prov = (sel[look_idx] == strong_gselect || sel[look_idx] == weak_gselect) ?
                       prov_gselect : prov_perceptron;
    assign look_taken = (look_prov == prov_gselect) ? gs_pred : pc_pred;

    // Output register is free or being drained this cycle
    assign advance = !rsp_valid || rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                sel[i] <= weak_gselect;
            end
        end else if (train_valid && gs_train_pred != pc_train_pred) begin
            // Only a disagreement says which component was right
            sel[train_idx] <= step_sel(sel[train_idx], pc_train_pred == train.taken);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (advance) begin
            rsp_valid <= look_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && look_valid) begin
            rsp.pc       <= look.pc;
            rsp.taken    <= look_taken;
            rsp.provider <= look_prov;
        end
    end

endmodule

//--- design/branch_predictor_top.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_predictor_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  bp_types_pkg::bp_req_t   req,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output bp_types_pkg::bp_rsp_t   rsp,
    input  logic                    upd_valid,
    output logic                    upd_ready,
    input  logic [31:0]             upd_pc,
    input  logic                    upd_taken
);

    import bp_types_pkg::*;

    logic [`BP_HIST_W-1:0] hist;
    logic                  train_valid;
    bp_upd_t               train;
    logic                  look_valid;
    bp_lookup_t            look;
    logic                  advance;
    logic                  gs_pred;
    logic                  pc_pred;
    logic                  gs_train_pred;
    logic                  pc_train_pred;

    bp_update_stage bp_update_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .upd_valid   (upd_valid),
        .upd_ready   (upd_ready),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .train_valid (train_valid),
        .train       (train),
        .hist        (hist)
    );

    bp_lookup_stage bp_lookup_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .hist       (hist),
        .advance    (advance),
        .look_valid (look_valid),
        .look       (look)
    );

    gselect_table gselect_table_inst (
        .clk         (clk),
        .rst         (rst),
        .look        (look),
        .pred        (gs_pred),
        .train_valid (train_valid),
        .train       (train),
        .train_pred  (gs_train_pred)
    );

    perceptron_table perceptron_table_inst (
        .clk         (clk),
        .rst         (rst),
        .look        (look),
        .pred        (pc_pred),
        .train_valid (train_valid),
        .train       (train),
        .train_pred  (pc_train_pred)
    );

    tournament_chooser tournament_chooser_inst (
        .clk           (clk),
        .rst           (rst),
        .look_valid    (look_valid),
        .look          (look),
        .gs_pred       (gs_pred),
        .pc_pred       (pc_pred),
        .advance       (advance),
        .train_valid   (train_valid),
        .train         (train),
        .gs_train_pred (gs_train_pred),
        .pc_train_pred (pc_train_pred),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp           (rsp)
    );

endmodule

//--- bench/tb_branch_predictor.sv
`timescale 1ns/1ps
`include "bp_defines.svh"

module tb_branch_predictor;

    import bp_types_pkg::*;

    localparam int GS_ENTRIES  = 1 << (`BP_HIST_W + `BP_PC_W);
    localparam int PT_ENTRIES  = 1 << `BP_PT_PC_W;
    localparam int SEL_ENTRIES = 1 << `BP_SEL_PC_W;
    localparam int W_MAX       = (1 << (`BP_WEIGHT_W - 1)) - 1;
    localparam int W_MIN       = -(1 << (`BP_WEIGHT_W - 1));
    localparam int WAIT_LIMIT  = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    bp_req_t     req;
    logic        rsp_valid;
    logic        rsp_ready;
    bp_rsp_t     rsp;
    logic        upd_valid;
    logic        upd_ready;
    logic [31:0] upd_pc;
    logic        upd_taken;

    // Reference predictor state
    logic [`BP_HIST_W-1:0] model_hist;
    int                    pht [GS_ENTRIES];
    int                    wt [PT_ENTRIES][`BP_HIST_W+1];
    int                    sel [SEL_ENTRIES];

    logic [31:0] rand_state = 32'd48952;
    int          cyc = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          mark_checks = 0;
    int          mark_fails = 0;
    bit          full_seen;
    logic [31:0] pcs [$];
    logic [33:0] expected_q [$];
    int          accept_q [$];

    branch_predictor_top branch_predictor_top_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .upd_valid (upd_valid),
        .upd_ready (upd_ready),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [15:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[31:16];
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] v;
        v[31:16] = next_rand();
        v[15:0]  = next_rand();
        return v;
    endfunction

    function automatic void reset_model();
        model_hist = '0;
        foreach (pht[i]) pht[i] = 1;
        foreach (wt[i, j]) wt[i][j] = 0;
        foreach (sel[i]) sel[i] = 1;
    endfunction

    function automatic int clamp_weight(input int v);
        int r;
        r = v;
        if (v > W_MAX) begin
            r = W_MAX;
        end else if (v < W_MIN) begin
            r = W_MIN;
        end
        return r;
    endfunction

    function automatic int perceptron_sum(input int idx, input logic [`BP_HIST_W-1:0] h);
        int acc;
        acc = wt[idx][0];
        for (int i = 0; i < `BP_HIST_W; i++) begin
            acc += h[i] ? wt[idx][i+1] : -wt[idx][i+1];
        end
        return acc;
    endfunction

    // Packed like the response struct: pc, taken, provider
    function automatic logic [33:0] expected_rsp(input logic [31:0] pc);
        logic gs;
        logic pt;
        logic prov;
        gs   = pht[{model_hist, pc[`BP_PC_W-1:0]}] >= 2;
        pt   = perceptron_sum(pc[`BP_PT_PC_W-1:0], model_hist) >= 0;
        prov = sel[pc[`BP_SEL_PC_W-1:0]] >= 2;
        return {pc, (prov ? pt : gs), prov};
    endfunction

    function automatic void train_model(input logic [31:0] pc, input logic taken);
        int   gidx;
        int   pidx;
        int   sidx;
        int   sum;
        logic gs;
        logic pt;
        gidx = {model_hist, pc[`BP_PC_W-1:0]};
        pidx = pc[`BP_PT_PC_W-1:0];
        sidx = pc[`BP_SEL_PC_W-1:0];
        gs   = pht[gidx] >= 2;
        sum  = perceptron_sum(pidx, model_hist);
        pt   = sum >= 0;
        // Chooser steps only when the components disagree
        if (gs != pt) begin
            if (pt == taken) begin
                sel[sidx] = (sel[sidx] < 3) ? sel[sidx] + 1 : 3;
            end else begin
                sel[sidx] = (sel[sidx] > 0) ? sel[sidx] - 1 : 0;
            end
        end
        if (taken) begin
            pht[gidx] = (pht[gidx] < 3) ? pht[gidx] + 1 : 3;
        end else begin
            pht[gidx] = (pht[gidx] > 0) ? pht[gidx] - 1 : 0;
        end
        if (pt != taken || (sum <= `BP_THETA && sum >= -`BP_THETA)) begin
            wt[pidx][0] = clamp_weight(wt[pidx][0] + (taken ? 1 : -1));
            for (int i = 0; i < `BP_HIST_W; i++) begin
                wt[pidx][i+1] = clamp_weight(wt[pidx][i+1] + ((model_hist[i] == taken) ? 1 : -1));
            end
        end
        model_hist = {model_hist[`BP_HIST_W-2:0], taken};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected === actual) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_hang(input string what);
        $display("Timeout: %s after %0d cycles", what, WAIT_LIMIT);
        $display("Verification failed");
        $finish;
    endtask

    task automatic close_test(input string name);
        $display("Test %s finished: %0d checks, %0d failed", name,
                 pass_count + fail_count - mark_checks, fail_count - mark_fails);
        mark_checks = pass_count + fail_count;
        mark_fails  = fail_count;
    endtask

    task automatic apply_update(input logic [31:0] pc, input logic taken);
        int waited;
        @(posedge clk);
        upd_valid <= 1'b1;
        upd_pc    <= pc;
        upd_taken <= taken;
        waited = 0;
        @(negedge clk);
        while (!upd_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_hang("update never accepted");
            end
            @(negedge clk);
        end
        train_model(pc, taken);
        @(posedge clk);
        upd_valid <= 1'b0;
    endtask

    // Issues every PC in pcs back to back and checks the responses in order
    task automatic run_requests(input string name, input bit stall);
        int          waited;
        int          idle;
        int          got;
        int          total;
        int          accepted;
        logic [15:0] roll;
        logic [33:0] exp_rsp;
        total = pcs.size();
        got   = 0;
        fork
            begin
                @(posedge clk);
                for (int i = 0; i < total; i++) begin
                    req_valid <= 1'b1;
                    req       <= '{pc: pcs[i]};
                    expected_q.push_back(expected_rsp(pcs[i]));
                    waited = 0;
                    @(negedge clk);
                    while (!req_ready) begin
                        full_seen = 1'b1;
                        waited++;
                        if (waited > WAIT_LIMIT) begin
                            report_hang("request never accepted");
                        end
                        @(negedge clk);
                    end
                    accept_q.push_back(cyc + 1);
                    @(posedge clk);
                end
                req_valid <= 1'b0;
            end
            begin
                idle = 0;
                while (got < total) begin
                    @(posedge clk);
                    roll = next_rand();
                    rsp_ready <= stall ? (roll[1:0] == 2'b00) : 1'b1;
                    @(negedge clk);
                    if (rsp_valid && rsp_ready) begin
                        exp_rsp  = expected_q.pop_front();
                        accepted = accept_q.pop_front();
                        check_value(name, exp_rsp, rsp);
                        if (!stall) begin
                            // The response transfers on the next rising edge
                            check_value({name, "_latency"}, 2, cyc + 1 - accepted);
                        end
                        got++;
                        idle = 0;
                    end else begin
                        idle++;
                        if (idle > WAIT_LIMIT) begin
                            report_hang("response never arrived");
                        end
                    end
                end
            end
        join
    endtask

    initial begin
        logic [31:0] pc;
        logic [15:0] roll;
        int          n;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        upd_valid = 1'b0;
        upd_pc    = '0;
        upd_taken = 1'b0;
        full_seen = 1'b0;
        reset_model();
        repeat (7) @(posedge clk);
        // Both ready outputs and rsp_valid stay low while reset is held
        @(negedge clk);
        check_value("reset_state", 0, {req_ready, upd_ready, rsp_valid});
        @(posedge clk);
        rst       <= 1'b0;
        rsp_ready <= 1'b1;

        pcs.delete();
        repeat (16) pcs.push_back(rand_pc());
        run_requests("reset_state", 1'b0);
        close_test("reset_state");

        pc = rand_pc();
        for (int r = 0; r < 4; r++) begin
            repeat (5) apply_update(pc, 1'b1);
            pcs.delete();
            repeat (2) pcs.push_back(pc);
            run_requests("always_taken", 1'b0);
        end
        close_test("always_taken");

        // Alternating outcomes on a single branch
        pc = rand_pc();
        for (int r = 0; r < 10; r++) begin
            for (int k = 0; k < 6; k++) begin
                apply_update(pc, k[0]);
            end
            pcs.delete();
            pcs.push_back(pc);
            run_requests("periodic", 1'b0);
        end
        close_test("periodic");

        full_seen = 1'b0;
        for (int r = 0; r < 3; r++) begin
            pcs.delete();
            repeat (12) pcs.push_back(rand_pc());
            run_requests("backpressure", 1'b1);
        end
        check_value("backpressure_full", 1, full_seen);
        close_test("backpressure");

        for (int r = 0; r < 6; r++) begin
            n = 4 + next_rand() % 9;
            repeat (n) begin
                pc   = rand_pc() & 32'h0000_00ff;
                roll = next_rand();
                apply_update(pc, roll < 16'hb000);
            end
            n = 4 + next_rand() % 7;
            pcs.delete();
            repeat (n) pcs.push_back(rand_pc() & 32'h0000_00ff);
            roll = next_rand();
            run_requests("random_mixed", roll[0]);
        end
        close_test("random_mixed");

        pcs.delete();
        repeat (8) pcs.push_back(rand_pc());
        run_requests("latency", 1'b0);
        close_test("latency");

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+design
design/bp_ctrl_pkg.sv
design/bp_types_pkg.sv
design/bp_update_stage.sv
design/bp_lookup_stage.sv
design/gselect_table.sv
design/perceptron_table.sv
design/tournament_chooser.sv
design/branch_predictor_top.sv
bench/tb_branch_predictor.sv

//--- Bender.yml
package:
  name: branch_predictor

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/bp_ctrl_pkg.sv
      - design/bp_types_pkg.sv
      - design/bp_update_stage.sv
      - design/bp_lookup_stage.sv
      - design/gselect_table.sv
      - design/perceptron_table.sv
      - design/tournament_chooser.sv
      - design/branch_predictor_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_branch_predictor.sv
